//--- build.f
verilog/rename_pkg.sv
verilog/disp_if.sv
verilog/decoder.sv
verilog/rename_unit.sv
verilog/dispatch_stage.sv
verilog/rob.sv
verilog/rename_core.sv
tests/rename_core_asserts.sv
tests/rename_core_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rename_core_tb
FILELIST = build.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@! grep -q "RESULT: FAIL" $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- tests/rename_core_tb.sv
// directed testbench for the rename core
// reference model of map, ready bits, free list and rob
// per-cycle compare of dispatch and retire outputs
`default_nettype none

module rename_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic clock, reset_i, complete_valid;
    logic [1:0] inst_valid, rs_free, accept_cnt, disp_valid, src1_rdy, src2_rdy, illegal;
    logic [1:0][31:0] inst;
    logic [3:0] complete_idx;
    logic [1:0][3:0] rob_idx;
    logic [1:0][5:0] dest_tag, src1_tag, src2_tag;
    rename_pkg::fu_e [1:0] fu;
    logic retire_valid;
    logic [4:0] retire_arch;
    logic [5:0] retire_tag;

    // reference model state
    int map_m [32];
    bit rdy_m [64];
    int freeq [$];
    int r_arch [16], r_new [16], r_old [16];
    bit r_dest [16], r_done [16];
    int r_head, r_tail, r_cnt, errors, checks;
    logic [31:0] seed;

    rename_core UUT (
        .clock(clock), .reset_i(reset_i), .inst_valid_i(inst_valid), .inst_i(inst),
        .rs_free_i(rs_free), .complete_valid_i(complete_valid), .complete_idx_i(complete_idx),
        .accept_cnt_o(accept_cnt), .disp_valid_o(disp_valid), .disp_rob_idx_o(rob_idx),
        .disp_dest_tag_o(dest_tag), .disp_src1_tag_o(src1_tag), .disp_src2_tag_o(src2_tag),
        .disp_src1_rdy_o(src1_rdy), .disp_src2_rdy_o(src2_rdy), .disp_fu_o(fu),
        .disp_illegal_o(illegal), .retire_valid_o(retire_valid), .retire_arch_o(retire_arch),
        .retire_tag_o(retire_tag)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic check(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("** Error @ %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic int next_reg();
        seed = seed * 32'd1664525 + 32'd1013904223;   // lcg
        return int'(seed[20:16]);
    endfunction

    function automatic logic [31:0] enc(input logic [6:0] op, input int rd, rs1, rs2);
        return {7'b0, 5'(rs2), 5'(rs1), 3'b0, 5'(rd), op};
    endfunction

    // reference decode by opcode
    // srcs marks two register sources
    function automatic void decode(input logic [31:0] ins, output bit has, output int rd,
                                   output int rs1, output int rs2, output int fu_x,
                                   output bit ill, output bit srcs);
        rd = int'(ins[11:7]);
        rs1 = int'(ins[19:15]);
        rs2 = int'(ins[24:20]);
        has = 0;
        ill = 0;
        srcs = 0;
        fu_x = int'(rename_pkg::FU_ALU);
        case (ins[6:0])
            rename_pkg::OP: begin
                has = (rd != 0);
                srcs = 1;
            end
            rename_pkg::OP_IMM, rename_pkg::LUI: has = (rd != 0);
            rename_pkg::LOAD: begin
                has = (rd != 0);
                fu_x = int'(rename_pkg::FU_MEM);
            end
            rename_pkg::STORE: begin
                fu_x = int'(rename_pkg::FU_MEM);
                srcs = 1;
            end
            rename_pkg::BRANCH: begin
                fu_x = int'(rename_pkg::FU_BR);
                srcs = 1;
            end
            default: ill = 1;
        endcase
    endfunction

    // one cycle of drive, check and model update
    task automatic step(input logic [1:0] v, input logic [31:0] i0, i1, input int rsf,
                        input bit cv, input int ci);
        bit has [2], ill [2], srcs [2], al [2], ret, r1, r2;
        int rd [2], rs1 [2], rs2 [2], fu_x [2], nt [2];
        int n, pos, d, t1, t2, idx;
        inst_valid = v;
        inst = {i1, i0};
        rs_free = 2'(rsf);
        complete_valid = cv;
        complete_idx = 4'(ci);
        #1;
        for (int s = 0; s < 2; s++) begin
            decode(inst[s], has[s], rd[s], rs1[s], rs2[s], fu_x[s], ill[s], srcs[s]);
        end
        n = 2;
        if (rsf < n) n = rsf;
        if (16 - r_cnt < n) n = 16 - r_cnt;
        if (freeq.size() < n) n = freeq.size();
        d = int'(v[0] && n > 0) + int'(v[1] && n > 1);
        check("accept_cnt", accept_cnt, d);
        pos = 0;
        for (int s = 0; s < 2; s++) begin
            check("disp_valid", disp_valid[s], int'(s < d));
            al[s] = (s < d) && has[s];
            nt[s] = al[s] ? freeq[pos] : 0;
            if (al[s]) pos++;
            if (s < d) begin
                check("rob_idx", rob_idx[s], (r_tail + s) % 16);
                check("dest_tag", dest_tag[s], nt[s]);
                check("illegal", illegal[s], ill[s]);
                if (!ill[s]) check("fu", int'(fu[s]), fu_x[s]);
            end
            if (s < d && srcs[s]) begin
                t1 = map_m[rs1[s]];
                t2 = map_m[rs2[s]];
                r1 = rdy_m[t1];
                r2 = rdy_m[t2];
                if (s == 1 && al[0] && rd[0] == rs1[1]) {t1, r1} = {nt[0], 1'b0};
                if (s == 1 && al[0] && rd[0] == rs2[1]) {t2, r2} = {nt[0], 1'b0};
                check("src1_tag", src1_tag[s], t1);
                check("src2_tag", src2_tag[s], t2);
                check("src1_rdy", src1_rdy[s], r1);
                check("src2_rdy", src2_rdy[s], r2);
            end
        end
        ret = (r_cnt > 0) && r_done[r_head];
        check("retire_valid", retire_valid, ret);
        if (ret && r_dest[r_head]) begin
            check("retire_tag", retire_tag, r_new[r_head]);
            check("retire_arch", retire_arch, r_arch[r_head]);
        end
        // rising edge effects
        for (int s = 0; s < d; s++) begin
            idx = (r_tail + s) % 16;
            r_arch[idx] = rd[s];
            r_new[idx] = nt[s];
            r_old[idx] = map_m[rd[s]];   // sees slot 0 rename
            r_dest[idx] = has[s];
            r_done[idx] = 0;
            if (al[s]) begin
                map_m[rd[s]] = nt[s];
                rdy_m[nt[s]] = 0;
            end
        end
        repeat (pos) void'(freeq.pop_front());
        r_tail = (r_tail + d) % 16;
        r_cnt += d;
        if (cv) begin
            r_done[ci] = 1;
            if (r_dest[ci]) rdy_m[r_new[ci]] = 1;
        end
        if (ret) begin
            if (r_dest[r_head]) freeq.push_back(r_old[r_head]);
            r_head = (r_head + 1) % 16;
            r_cnt--;
        end
        @(negedge clock);
    endtask

    // oldest incomplete rob entry or -1
    function automatic int pending();
        for (int k = 0; k < r_cnt; k++) begin
            if (!r_done[(r_head + k) % 16]) return (r_head + k) % 16;
        end
        return -1;
    endfunction

    task automatic drain();
        int guard, ci;
        guard = 0;
        while (r_cnt > 0 && guard < 100) begin
            ci = pending();
            step(2'b00, 0, 0, 2, ci >= 0, ci < 0 ? 0 : ci);
            guard++;
        end
        if (r_cnt > 0) begin
            errors++;
            $display("timeout: reorder buffer did not drain within %0d cycles", guard);
        end
    endtask

    task automatic test_reset_state();
        step(2'b01, enc(rename_pkg::OP, 1, 2, 3), 0, 2, 0, 0);   // reads tags 2 and 3, gets 32
    endtask

    task automatic test_group_dep();
        step(2'b11, enc(rename_pkg::OP, 5, 1, 1), enc(rename_pkg::OP, 6, 5, 2), 2, 0, 0);
        step(2'b01, enc(rename_pkg::OP, 7, 5, 0), 0, 2, 0, 0);
    endtask

    task automatic test_backpressure();
        int guard;
        for (int r = 0; r < 3; r++) begin
            step(2'b11, enc(rename_pkg::OP, next_reg(), next_reg(), next_reg()),
                 enc(rename_pkg::OP, next_reg(), next_reg(), next_reg()), r, 0, 0);
        end
        guard = 0;
        while (r_cnt < 16 && guard < 20) begin
            step(2'b11, enc(rename_pkg::OP, next_reg(), next_reg(), next_reg()),
                 enc(rename_pkg::OP, next_reg(), next_reg(), next_reg()), 2, 0, 0);
            guard++;
        end
        check("rob full", r_cnt, 16);
        step(2'b11, enc(rename_pkg::OP, 3, 4, 5), enc(rename_pkg::OP, 6, 7, 8), 2, 0, 0);
        check("accept while full", accept_cnt, 0);
    endtask

    task automatic test_complete_retire();
        for (int k = 15; k >= 0; k--) begin
            step(2'b00, 0, 0, 2, 1, (r_head + k) % 16);   // head last
        end
        drain();
        step(2'b11, enc(rename_pkg::OP, 9, next_reg(), next_reg()),
             enc(rename_pkg::OP, 10, next_reg(), next_reg()), 2, 0, 0);
        drain();
    endtask

    task automatic test_recycle();
        int ci;
        for (int c = 0; c < 40; c++) begin
            ci = pending();
            step(2'b11, enc(rename_pkg::OP, next_reg(), next_reg(), next_reg()),
                 enc(rename_pkg::OP, next_reg(), next_reg(), next_reg()), 2,
                 ci >= 0, ci < 0 ? 0 : ci);
        end
        drain();
    endtask

    task automatic test_decode_edges();
        step(2'b11, enc(rename_pkg::STORE, 4, 1, 2), enc(rename_pkg::BRANCH, 8, 3, 4), 2, 0, 0);
        step(2'b01, enc(rename_pkg::OP, 0, 1, 2), 0, 2, 0, 0);
        // lui in slot 1 must still get the untouched free-list head
        step(2'b11, enc(7'h7f, 3, 1, 2), enc(rename_pkg::LUI, 11, 0, 0), 2, 0, 0);
        check("illegal slot 0", illegal[0], 1);
        drain();
    endtask

    initial begin
        reset_i = 1'b1;
        inst_valid = '0;
        inst = '0;
        rs_free = '0;
        complete_valid = 1'b0;
        complete_idx = '0;
        seed = 32'h680ad298;
        errors = 0;
        checks = 0;
        {r_head, r_tail, r_cnt} = '0;
        for (int i = 0; i < 32; i++) map_m[i] = i;
        for (int i = 0; i < 64; i++) rdy_m[i] = 1;
        for (int i = 32; i < 64; i++) freeq.push_back(i);
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset_i = 1'b0;

        test_reset_state();
        test_group_dep();
        test_backpressure();
        test_complete_retire();
        test_recycle();
        test_decode_edges();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/rename_core_asserts.sv
// concurrent checks on the rename core top level
// slot contiguity, rs limit, retire quiet in reset
`default_nettype none

module rename_core_asserts (
    input wire       clock,
    input wire       reset_i,
    input wire [1:0] disp_valid_o,
    input wire [1:0] accept_cnt_o,
    input wire [1:0] rs_free_i,
    input wire       retire_valid_o
);
    timeunit 1ns;
    timeprecision 1ps;

    slot_order: assert property (@(posedge clock) disable iff (reset_i)
        disp_valid_o[1] |-> disp_valid_o[0])
        else $error("slot 1 dispatched without slot 0");

    rs_limit: assert property (@(posedge clock) disable iff (reset_i)
        accept_cnt_o <= rs_free_i)
        else $error("accept count above free rs slots");

    // second reset cycle onward, state is cleared
    quiet_reset: assert property (@(posedge clock)
        reset_i && $past(reset_i) |-> !retire_valid_o)
        else $error("retire during reset");

endmodule

bind rename_core rename_core_asserts u_asserts (
    .clock          (clock),
    .reset_i        (reset_i),
    .disp_valid_o   (disp_valid_o),
    .accept_cnt_o   (accept_cnt_o),
    .rs_free_i      (rs_free_i),
    .retire_valid_o (retire_valid_o)
);

`default_nettype wire

//--- verilog/rename_core.sv
// two-wide rename and dispatch core, top level
// dispatch stage, rename unit and reorder buffer
`default_nettype none

module rename_core (
    input  wire                                                          clock,
    input  wire                                                          reset_i,
    input  wire  [rename_pkg::DISP_WIDTH-1:0]                            inst_valid_i,
    input  wire  [rename_pkg::DISP_WIDTH-1:0][31:0]                      inst_i,
    input  wire  [rename_pkg::CNT_W-1:0]                                 rs_free_i,
    input  wire                                                          complete_valid_i,
    input  wire  [rename_pkg::ROB_W-1:0]                                 complete_idx_i,
    output logic [rename_pkg::CNT_W-1:0]                                 accept_cnt_o,
    output logic [rename_pkg::DISP_WIDTH-1:0]                            disp_valid_o,
    output logic [rename_pkg::DISP_WIDTH-1:0][rename_pkg::ROB_W-1:0]     disp_rob_idx_o,
    output logic [rename_pkg::DISP_WIDTH-1:0][rename_pkg::PHYS_W-1:0]    disp_dest_tag_o,
    output logic [rename_pkg::DISP_WIDTH-1:0][rename_pkg::PHYS_W-1:0]    disp_src1_tag_o,
    output logic [rename_pkg::DISP_WIDTH-1:0][rename_pkg::PHYS_W-1:0]    disp_src2_tag_o,
    output logic [rename_pkg::DISP_WIDTH-1:0]                            disp_src1_rdy_o,
    output logic [rename_pkg::DISP_WIDTH-1:0]                            disp_src2_rdy_o,
    output rename_pkg::fu_e [rename_pkg::DISP_WIDTH-1:0]                 disp_fu_o,
    output logic [rename_pkg::DISP_WIDTH-1:0]                            disp_illegal_o,
    output logic                                                         retire_valid_o,
    output logic [rename_pkg::ARCH_W-1:0]                                retire_arch_o,
    output logic [rename_pkg::PHYS_W-1:0]                                retire_tag_o
);

    rename_if ren_bus ();
    rob_if    rob_bus ();

    dispatch_stage u_disp (
        .inst_valid_i    (inst_valid_i),
        .inst_i          (inst_i),
        .rs_free_i       (rs_free_i),
        .ren             (ren_bus.disp),
        .rob             (rob_bus.disp),
        .accept_cnt_o    (accept_cnt_o),
        .disp_valid_o    (disp_valid_o),
        .disp_rob_idx_o  (disp_rob_idx_o),
        .disp_dest_tag_o (disp_dest_tag_o),
        .disp_src1_tag_o (disp_src1_tag_o),
        .disp_src2_tag_o (disp_src2_tag_o),
        .disp_src1_rdy_o (disp_src1_rdy_o),
        .disp_src2_rdy_o (disp_src2_rdy_o),
        .disp_fu_o       (disp_fu_o),
        .disp_illegal_o  (disp_illegal_o)
    );

    rename_unit u_ren (
        .clock   (clock),
        .reset_i (reset_i),
        .ren     (ren_bus.ren),
        .rob     (rob_bus.ren)
    );

    rob u_rob (
        .clock            (clock),
        .reset_i          (reset_i),
        .rob              (rob_bus.rob),
        .complete_valid_i (complete_valid_i),
        .complete_idx_i   (complete_idx_i),
        .retire_valid_o   (retire_valid_o),
        .retire_arch_o    (retire_arch_o),
        .retire_tag_o     (retire_tag_o)
    );

endmodule

`default_nettype wire

//--- verilog/rob.sv
// 16-entry reorder buffer
// allocation at tail, completion by index, in-order retire at head
`default_nettype none

module rob (
    input  wire                             clock,
    input  wire                             reset_i,
    rob_if.rob                              rob,
    input  wire                             complete_valid_i,
    input  wire [rename_pkg::ROB_W-1:0]     complete_idx_i,
    output logic                            retire_valid_o,
    output logic [rename_pkg::ARCH_W-1:0]   retire_arch_o,
    output logic [rename_pkg::PHYS_W-1:0]   retire_tag_o
);

    // entry payload
    logic [rename_pkg::ARCH_W-1:0] e_arch [rename_pkg::ROB_DEPTH];
    logic [rename_pkg::PHYS_W-1:0] e_new  [rename_pkg::ROB_DEPTH];
    logic [rename_pkg::PHYS_W-1:0] e_old  [rename_pkg::ROB_DEPTH];
    logic [rename_pkg::ROB_DEPTH-1:0] e_dest;
    logic [rename_pkg::ROB_DEPTH-1:0] e_done;

    logic [rename_pkg::ROB_W-1:0] head;
    logic [rename_pkg::ROB_W-1:0] tail;
    logic [rename_pkg::ROB_W:0]   count;
    logic [rename_pkg::ROB_W:0]   n_free;
    logic [rename_pkg::ROB_W:0]   n_alloc;

    assign n_free  = (rename_pkg::ROB_W + 1)'(rename_pkg::ROB_DEPTH) - count;
    assign n_alloc = (rename_pkg::ROB_W + 1)'(rob.alloc_valid[0])
                   + (rename_pkg::ROB_W + 1)'(rob.alloc_valid[1]);

    assign rob.free_cnt = (n_free >= (rename_pkg::ROB_W + 1)'(rename_pkg::CNT_SAT)) ?
                          rename_pkg::CNT_SAT : n_free[rename_pkg::CNT_W-1:0];
    assign rob.tail_idx = tail;

    // wakeup at the completion edge
    assign rob.wake_valid = complete_valid_i && e_dest[complete_idx_i];
    assign rob.wake_tag   = e_new[complete_idx_i];

    assign retire_valid_o = (count != '0) && e_done[head];
    assign retire_arch_o  = e_arch[head];
    assign retire_tag_o   = e_new[head];
    assign rob.free_valid = retire_valid_o && e_dest[head];   // told back to free list
    assign rob.free_tag   = e_old[head];

    always_ff @(posedge clock) begin
        if (reset_i) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            e_done <= '0;
        end else begin
            for (int i = 0; i < rename_pkg::DISP_WIDTH; i++) begin
                if (rob.alloc_valid[i]) begin
                    e_arch[tail + (rename_pkg::ROB_W)'(i)] <= rob.dest_arch[i];
                    e_new[tail + (rename_pkg::ROB_W)'(i)]  <= rob.new_tag[i];
                    e_old[tail + (rename_pkg::ROB_W)'(i)]  <= rob.old_tag[i];
                    e_dest[tail + (rename_pkg::ROB_W)'(i)] <= rob.has_dest[i];
                    e_done[tail + (rename_pkg::ROB_W)'(i)] <= 1'b0;
                end
            end
            if (complete_valid_i) e_done[complete_idx_i] <= 1'b1;
            tail  <= tail + n_alloc[rename_pkg::ROB_W-1:0];
            head  <= head + (rename_pkg::ROB_W)'(retire_valid_o);
            count <= count + n_alloc - (rename_pkg::ROB_W + 1)'(retire_valid_o);
        end
    end

endmodule

`default_nettype wire

//--- verilog/dispatch_stage.sv
// decode, dispatch count and same-group bypass
// forms the reservation-station packet and rob allocation
`default_nettype none

module dispatch_stage (
    input  wire [rename_pkg::DISP_WIDTH-1:0]                             inst_valid_i,
    input  wire [rename_pkg::DISP_WIDTH-1:0][31:0]                       inst_i,
    input  wire [rename_pkg::CNT_W-1:0]                                  rs_free_i,
    rename_if.disp                                                       ren,
    rob_if.disp                                                          rob,
    output logic [rename_pkg::CNT_W-1:0]                                 accept_cnt_o,
    output logic [rename_pkg::DISP_WIDTH-1:0]                            disp_valid_o,
    output logic [rename_pkg::DISP_WIDTH-1:0][rename_pkg::ROB_W-1:0]     disp_rob_idx_o,
    output logic [rename_pkg::DISP_WIDTH-1:0][rename_pkg::PHYS_W-1:0]    disp_dest_tag_o,
    output logic [rename_pkg::DISP_WIDTH-1:0][rename_pkg::PHYS_W-1:0]    disp_src1_tag_o,
    output logic [rename_pkg::DISP_WIDTH-1:0][rename_pkg::PHYS_W-1:0]    disp_src2_tag_o,
    output logic [rename_pkg::DISP_WIDTH-1:0]                            disp_src1_rdy_o,
    output logic [rename_pkg::DISP_WIDTH-1:0]                            disp_src2_rdy_o,
    output rename_pkg::fu_e [rename_pkg::DISP_WIDTH-1:0]                 disp_fu_o,
    output logic [rename_pkg::DISP_WIDTH-1:0]                            disp_illegal_o
);

    rename_pkg::decoded_t             dec [rename_pkg::DISP_WIDTH];
    logic [rename_pkg::CNT_W-1:0]      disp_n;
    logic [rename_pkg::DISP_WIDTH-1:0] alloc;

    for (genvar i = 0; i < rename_pkg::DISP_WIDTH; i++) begin : gen_dec
        decoder u_dec (
            .inst_i (inst_i[i]),
            .dec_o  (dec[i])
        );
    end

    // =========================================================================
    // dispatch count, min of width, rs, rob and free regs
    // =========================================================================
    always_comb begin
        disp_n = rename_pkg::CNT_SAT;
        if (rs_free_i < disp_n)    disp_n = rs_free_i;
        if (rob.free_cnt < disp_n) disp_n = rob.free_cnt;
        if (ren.free_cnt < disp_n) disp_n = ren.free_cnt;
    end

    always_comb begin
        accept_cnt_o = '0;
        for (int i = 0; i < rename_pkg::DISP_WIDTH; i++) begin
            disp_valid_o[i]  = inst_valid_i[i] && (i < disp_n);
            alloc[i]         = disp_valid_o[i] && dec[i].has_dest;   // only real destinations pop
            accept_cnt_o     = accept_cnt_o + (rename_pkg::CNT_W)'(disp_valid_o[i]);
            ren.src1_arch[i] = dec[i].rs1;
            ren.src2_arch[i] = dec[i].rs2;
            ren.dest_arch[i] = dec[i].rd;
            disp_fu_o[i]     = dec[i].fu;
            disp_illegal_o[i] = dec[i].illegal;
            disp_rob_idx_o[i] = rob.tail_idx + (rename_pkg::ROB_W)'(i);   // wraps at 16
        end
        ren.alloc = alloc;
    end

    // =========================================================================
    // tags back from rename, bypass for slot 1
    // =========================================================================
    always_comb begin
        for (int i = 0; i < rename_pkg::DISP_WIDTH; i++) begin
            disp_src1_tag_o[i] = ren.src1_tag[i];
            disp_src2_tag_o[i] = ren.src2_tag[i];
            disp_src1_rdy_o[i] = ren.src1_rdy[i];
            disp_src2_rdy_o[i] = ren.src2_rdy[i];
            disp_dest_tag_o[i] = alloc[i] ? ren.new_tag[i] : '0;
            rob.old_tag[i]     = ren.old_tag[i];
        end
        // slot 0 rd not yet in the map table
        if (alloc[0] && (dec[0].rd == dec[1].rs1)) begin
            disp_src1_tag_o[1] = ren.new_tag[0];
            disp_src1_rdy_o[1] = 1'b0;
        end
        if (alloc[0] && (dec[0].rd == dec[1].rs2)) begin
            disp_src2_tag_o[1] = ren.new_tag[0];
            disp_src2_rdy_o[1] = 1'b0;
        end
        if (alloc[0] && (dec[0].rd == dec[1].rd)) rob.old_tag[1] = ren.new_tag[0];   // waw in group
    end

    assign rob.alloc_valid = disp_valid_o;
    assign rob.new_tag     = ren.new_tag;
    assign rob.dest_arch   = {dec[1].rd, dec[0].rd};
    assign rob.has_dest    = {dec[1].has_dest, dec[0].has_dest};

endmodule

`default_nettype wire

//--- verilog/rename_unit.sv
// map table, physical ready bits and circular free list
// combinational lookups, updates at the clock edge
`default_nettype none

module rename_unit (
    input wire    clock,
    input wire    reset_i,
    rename_if.ren ren,
    rob_if.ren    rob
);

    logic [rename_pkg::PHYS_W-1:0] map_table [rename_pkg::ARCH_REGS];
    logic [rename_pkg::PHYS_REGS-1:0] ready;
    logic [rename_pkg::PHYS_W-1:0] free_list [rename_pkg::FREE_DEPTH];
    logic [rename_pkg::FREE_W-1:0] head;
    logic [rename_pkg::FREE_W-1:0] head_p1;
    logic [rename_pkg::FREE_W-1:0] tail;
    logic [rename_pkg::FREE_W:0]   count;     // 0 to 32 entries
    logic [rename_pkg::CNT_W-1:0]  n_alloc;

    // =========================================================================
    // lookups
    // =========================================================================
    always_comb begin
        for (int i = 0; i < rename_pkg::DISP_WIDTH; i++) begin
            ren.src1_tag[i] = map_table[ren.src1_arch[i]];
            ren.src2_tag[i] = map_table[ren.src2_arch[i]];
            ren.src1_rdy[i] = ready[map_table[ren.src1_arch[i]]];
            ren.src2_rdy[i] = ready[map_table[ren.src2_arch[i]]];
            ren.old_tag[i]  = map_table[ren.dest_arch[i]];   // told
        end
    end

    assign head_p1 = head + 1'b1;
    // slot 1 takes the head when slot 0 has no destination
    assign ren.new_tag  = {ren.alloc[0] ? free_list[head_p1] : free_list[head], free_list[head]};
    assign ren.free_cnt = (count >= (rename_pkg::FREE_W + 1)'(rename_pkg::CNT_SAT)) ?
                          rename_pkg::CNT_SAT : count[rename_pkg::CNT_W-1:0];
    assign n_alloc      = (rename_pkg::CNT_W)'(ren.alloc[0]) + (rename_pkg::CNT_W)'(ren.alloc[1]);

    // =========================================================================
    // state update
    // =========================================================================
    always_ff @(posedge clock) begin
        if (reset_i) begin
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                map_table[i] <= (rename_pkg::PHYS_W)'(i);   // identity map
            end
            for (int i = 0; i < rename_pkg::FREE_DEPTH; i++) begin
                free_list[i] <= (rename_pkg::PHYS_W)'(rename_pkg::ARCH_REGS + i);
            end
            ready <= '1;
            head  <= '0;
            tail  <= '0;
            count <= (rename_pkg::FREE_W + 1)'(rename_pkg::FREE_DEPTH);
        end else begin
            // later slot wins on the same rd
            for (int i = 0; i < rename_pkg::DISP_WIDTH; i++) begin
                if (ren.alloc[i]) begin
                    map_table[ren.dest_arch[i]] <= ren.new_tag[i];
                    ready[ren.new_tag[i]]       <= 1'b0;
                end
            end
            if (rob.wake_valid) ready[rob.wake_tag] <= 1'b1;
            if (rob.free_valid) begin
                free_list[tail] <= rob.free_tag;   // push at tail
                tail            <= tail + 1'b1;
            end
            head  <= head + (rename_pkg::FREE_W)'(n_alloc);
            count <= count + (rename_pkg::FREE_W + 1)'(rob.free_valid)
                           - (rename_pkg::FREE_W + 1)'(n_alloc);
        end
    end

endmodule

`default_nettype wire

//--- verilog/decoder.sv
// single-slot decoder for the rv32i subset
// register fields, destination flag, unit select, illegal flag
`default_nettype none

module decoder (
    input  wire [31:0]          inst_i,
    output rename_pkg::decoded_t dec_o
);

    rename_pkg::opcode_e opcode;

    assign opcode = rename_pkg::opcode_e'(inst_i[6:0]);

    always_comb begin
        dec_o          = '0;
        dec_o.rd       = inst_i[11:7];
        dec_o.rs1      = inst_i[19:15];
        dec_o.rs2      = inst_i[24:20];
        dec_o.fu       = rename_pkg::FU_ALU;
        dec_o.illegal  = 1'b0;
        dec_o.has_dest = 1'b0;

        case (opcode)
            rename_pkg::OP: begin
                dec_o.has_dest = (inst_i[11:7] != '0);   // x0 writes dropped
            end
            rename_pkg::OP_IMM: begin
                dec_o.rs2      = '0;   // immediate in place of rs2
                dec_o.has_dest = (inst_i[11:7] != '0);
            end
            rename_pkg::LOAD: begin
                dec_o.rs2      = '0;
                dec_o.fu       = rename_pkg::FU_MEM;
                dec_o.has_dest = (inst_i[11:7] != '0);
            end
            rename_pkg::STORE: begin
                dec_o.fu = rename_pkg::FU_MEM;   // rs2 is store data
            end
            rename_pkg::BRANCH: begin
                dec_o.fu = rename_pkg::FU_BR;
            end
            rename_pkg::LUI: begin
                dec_o.rs1      = '0;   // no register sources
                dec_o.rs2      = '0;
                dec_o.has_dest = (inst_i[11:7] != '0);
            end
            default: begin
                // unknown opcode, read x0 only
                dec_o.rs1     = '0;
                dec_o.rs2     = '0;
                dec_o.illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/disp_if.sv
// rename_if: dispatch to map table and free list
// rob_if: dispatch allocation, wake and free strobes
`default_nettype none

interface rename_if;
    logic [rename_pkg::DISP_WIDTH-1:0][rename_pkg::ARCH_W-1:0] src1_arch;
    logic [rename_pkg::DISP_WIDTH-1:0][rename_pkg::ARCH_W-1:0] src2_arch;
    logic [rename_pkg::DISP_WIDTH-1:0][rename_pkg::ARCH_W-1:0] dest_arch;
    logic [rename_pkg::DISP_WIDTH-1:0]                         alloc;     // pops in slot order
    logic [rename_pkg::DISP_WIDTH-1:0][rename_pkg::PHYS_W-1:0] src1_tag;
    logic [rename_pkg::DISP_WIDTH-1:0][rename_pkg::PHYS_W-1:0] src2_tag;
    logic [rename_pkg::DISP_WIDTH-1:0]                         src1_rdy;
    logic [rename_pkg::DISP_WIDTH-1:0]                         src2_rdy;
    logic [rename_pkg::DISP_WIDTH-1:0][rename_pkg::PHYS_W-1:0] old_tag;
    logic [rename_pkg::DISP_WIDTH-1:0][rename_pkg::PHYS_W-1:0] new_tag;
    logic [rename_pkg::CNT_W-1:0]                              free_cnt;

    modport disp (output src1_arch, src2_arch, dest_arch, alloc,
                  input  src1_tag, src2_tag, src1_rdy, src2_rdy, old_tag, new_tag, free_cnt);
    modport ren  (input  src1_arch, src2_arch, dest_arch, alloc,
                  output src1_tag, src2_tag, src1_rdy, src2_rdy, old_tag, new_tag, free_cnt);
endinterface

interface rob_if;
    logic [rename_pkg::DISP_WIDTH-1:0]                         alloc_valid;
    logic [rename_pkg::DISP_WIDTH-1:0][rename_pkg::ARCH_W-1:0] dest_arch;
    logic [rename_pkg::DISP_WIDTH-1:0][rename_pkg::PHYS_W-1:0] new_tag;
    logic [rename_pkg::DISP_WIDTH-1:0][rename_pkg::PHYS_W-1:0] old_tag;
    logic [rename_pkg::DISP_WIDTH-1:0]                         has_dest;
    logic [rename_pkg::CNT_W-1:0]                              free_cnt;
    logic [rename_pkg::ROB_W-1:0]                              tail_idx;
    logic                                                      wake_valid;   // completion wakeup
    logic [rename_pkg::PHYS_W-1:0]                             wake_tag;
    logic                                                      free_valid;   // retired old tag
    logic [rename_pkg::PHYS_W-1:0]                             free_tag;

    modport disp (output alloc_valid, dest_arch, new_tag, old_tag, has_dest,
                  input  free_cnt, tail_idx);
    modport rob  (input  alloc_valid, dest_arch, new_tag, old_tag, has_dest,
                  output free_cnt, tail_idx, wake_valid, wake_tag, free_valid, free_tag);
    modport ren  (input  wake_valid, wake_tag, free_valid, free_tag);
endinterface

`default_nettype wire

//--- verilog/rename_pkg.sv
// widths and sizes shared by the rename core
// opcode and function-unit enums
// decoded instruction struct
`default_nettype none

package rename_pkg;

    localparam int DISP_WIDTH = 2;   // slots per cycle
    localparam int ARCH_REGS  = 32;
    localparam int ARCH_W     = 5;
    localparam int PHYS_REGS  = 64;
    localparam int PHYS_W     = 6;
    localparam int ROB_DEPTH  = 16;
    localparam int ROB_W      = 4;
    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;   // free list holds the extra tags
    localparam int FREE_W     = 5;
    localparam int CNT_W      = 2;   // free counts saturate at two

    localparam logic [CNT_W-1:0] CNT_SAT = CNT_W'(DISP_WIDTH);

    // rv32i major opcodes, subset only
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [1:0] {
        FU_ALU,
        FU_MEM,
        FU_BR
    } fu_e;

    typedef struct packed {
        logic              has_dest;   // writes a register other than x0
        logic [ARCH_W-1:0] rd;
        logic [ARCH_W-1:0] rs1;
        logic [ARCH_W-1:0] rs2;
        fu_e               fu;
        logic              illegal;
    } decoded_t;

endpackage

`default_nettype wire
